// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = asp_shell_tb
FILELIST  = asp_shell.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

// File: asp_shell.f
source/asp_pkg.sv
source/mmio_csr.sv
source/kernel_lane.sv
source/completion_collector.sv
source/asp_shell_top.sv
verification/asp_shell_tb.sv

// File: source/asp_pkg.sv
// Encodings and field positions shared by the accelerator shell RTL and its testbench
// Modules pull these in with a wildcard import in their header
package asp_pkg;

    // Lane kernel opcodes, carried in bits 1:0 of a COMMAND write
    typedef enum logic [1:0] {
        OP_FILL = 2'd0,
        OP_ADD  = 2'd1,
        OP_SUM  = 2'd2
    } kernel_op_t;

    // MMIO word addresses
    typedef enum logic [2:0] {
        CSR_ARG_BASE    = 3'd0,
        CSR_ARG_LEN     = 3'd1,
        CSR_ARG_OPERAND = 3'd2,
        CSR_COMMAND     = 3'd3,
        CSR_STATUS      = 3'd4,
        CSR_RESULT_INFO = 3'd5,
        CSR_RESULT_DATA = 3'd6
    } csr_addr_t;

    // Lane index in a COMMAND write
    localparam int CMD_LANE_LSB = 8;

    // STATUS: busy bits from bit 0, result count from here
    localparam int STATUS_COUNT_LSB = 16;

    // RESULT_INFO layout, opcode stays in bits 1:0
    localparam int INFO_VALID_BIT = 31;
    localparam int INFO_LANE_LSB  = 8;

    // Bits needed to index n values, never less than one
    function automatic int width_for(input int n);
        int w;
        w = 1;
        if (n > 1) begin
            w = $clog2(n);
        end
        return w;
    endfunction

endpackage

// File: source/asp_shell_top.sv
// Top level of the accelerator shell: MMIO control block, a row of compute lanes
// and the completion collector, all on pClk
module asp_shell_top
    import asp_pkg::*;
#(
    parameter int NUM_LANES    = 4,
    parameter int LANE_ADDR_W  = 6,
    parameter int DATA_W       = 32,
    parameter int RESULT_DEPTH = 4
) (
    input  logic              pClk,
    input  logic              rst_n,
    input  logic              mmio_req,
    input  logic              mmio_write,
    input  logic [2:0]        mmio_addr,
    input  logic [DATA_W-1:0] mmio_wdata,
    output logic              mmio_ack,
    output logic [DATA_W-1:0] mmio_rdata
);
    localparam int LANE_IDX_W = width_for(NUM_LANES);
    localparam int CNT_W      = width_for(RESULT_DEPTH + 1);

    // Launch side, shared buses fan out to every lane
    logic [NUM_LANES-1:0]   lane_req;
    logic [NUM_LANES-1:0]   lane_ack;
    logic [NUM_LANES-1:0]   lane_busy;
    kernel_op_t             lane_op;
    logic [LANE_ADDR_W-1:0] lane_base;
    logic [LANE_ADDR_W:0]   lane_len;
    logic [DATA_W-1:0]      lane_operand;

    // Completion side
    logic [NUM_LANES-1:0]             done_req;
    logic [NUM_LANES-1:0]             done_ack;
    kernel_op_t [NUM_LANES-1:0]       done_op;
    logic [NUM_LANES-1:0][DATA_W-1:0] done_result;

    // Result queue head
    logic                  head_valid;
    logic [LANE_IDX_W-1:0] head_lane;
    kernel_op_t            head_op;
    logic [DATA_W-1:0]     head_result;
    logic [CNT_W-1:0]      count;
    logic                  pop;

    mmio_csr #(
        .NUM_LANES    (NUM_LANES),
        .LANE_ADDR_W  (LANE_ADDR_W),
        .DATA_W       (DATA_W),
        .RESULT_DEPTH (RESULT_DEPTH)
    ) u_csr (
        .pClk, .rst_n,
        .mmio_req, .mmio_write, .mmio_addr, .mmio_wdata, .mmio_ack, .mmio_rdata,
        .lane_req, .lane_op, .lane_base, .lane_len, .lane_operand,
        .lane_ack, .lane_busy,
        .head_valid, .head_lane, .head_op, .head_result, .count, .pop
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        kernel_lane #(
            .LANE_ADDR_W (LANE_ADDR_W),
            .DATA_W      (DATA_W)
        ) u_lane (
            .pClk, .rst_n,
            .lane_req     (lane_req[i]),
            .lane_op, .lane_base, .lane_len, .lane_operand,
            .done_ack     (done_ack[i]),
            .lane_ack     (lane_ack[i]),
            .lane_busy    (lane_busy[i]),
            .done_req     (done_req[i]),
            .done_op      (done_op[i]),
            .done_result  (done_result[i])
        );
    end

    completion_collector #(
        .NUM_LANES    (NUM_LANES),
        .DATA_W       (DATA_W),
        .RESULT_DEPTH (RESULT_DEPTH)
    ) u_collector (
        .pClk, .rst_n,
        .done_req, .done_op, .done_result, .pop, .done_ack,
        .head_valid, .head_lane, .head_op, .head_result, .count
    );

endmodule

// File: source/completion_collector.sv
// Collects lane completions round-robin into a small circular result FIFO
// The MMIO block reads the head and pops it
module completion_collector
    import asp_pkg::*;
#(
    parameter int  NUM_LANES    = 4,
    parameter int  DATA_W       = 32,
    parameter int  RESULT_DEPTH = 4,
    localparam int LANE_IDX_W   = width_for(NUM_LANES),
    localparam int CNT_W        = width_for(RESULT_DEPTH + 1),
    localparam int PTR_W        = width_for(RESULT_DEPTH)
) (
    input  logic                              pClk,
    input  logic                              rst_n,
    input  logic [NUM_LANES-1:0]              done_req,
    input  kernel_op_t [NUM_LANES-1:0]        done_op,
    input  logic [NUM_LANES-1:0][DATA_W-1:0]  done_result,
    input  logic                              pop,
    output logic [NUM_LANES-1:0]              done_ack,
    output logic                              head_valid,
    output logic [LANE_IDX_W-1:0]             head_lane,
    output kernel_op_t                        head_op,
    output logic [DATA_W-1:0]                 head_result,
    output logic [CNT_W-1:0]                  count
);
    logic [LANE_IDX_W-1:0] fifo_lane   [RESULT_DEPTH];
    kernel_op_t            fifo_op     [RESULT_DEPTH];
    logic [DATA_W-1:0]     fifo_result [RESULT_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [LANE_IDX_W-1:0] rr_ptr;
    logic [LANE_IDX_W-1:0] grant_idx;
    logic                  grant_valid;
    logic                  full;
    logic                  push;
    logic                  do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(RESULT_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // First requesting lane at or after the round-robin pointer
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_idx   = rr_ptr;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= NUM_LANES) begin
                idx = idx - NUM_LANES;
            end
            if (!grant_valid && done_req[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = LANE_IDX_W'(idx);
            end
        end
    end

    assign full   = (count == CNT_W'(RESULT_DEPTH));
    // Only one done handshake open at a time
    assign push   = grant_valid && (done_ack == '0) && !full;
    assign do_pop = pop && head_valid;

    assign head_valid  = (count != '0);
    assign head_lane   = fifo_lane[rd_ptr];
    assign head_op     = fifo_op[rd_ptr];
    assign head_result = fifo_result[rd_ptr];

    always_ff @(posedge pClk) begin
        if (push) begin
            fifo_lane[wr_ptr]   <= grant_idx;
            fifo_op[wr_ptr]     <= done_op[grant_idx];
            fifo_result[wr_ptr] <= done_result[grant_idx];
        end
    end

    always_ff @(posedge pClk or negedge rst_n) begin
        if (!rst_n) begin
            done_ack <= '0;
            rr_ptr   <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (done_ack[i] && !done_req[i]) begin
                    done_ack[i] <= 1'b0;
                end
            end
            if (push) begin
                done_ack[grant_idx] <= 1'b1;
                wr_ptr              <= ptr_inc(wr_ptr);
                rr_ptr              <= (grant_idx == LANE_IDX_W'(NUM_LANES - 1)) ? '0
                                                                       : grant_idx + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/kernel_lane.sv
// One compute lane: a private bank of words and the FSM that runs a fill, add or
// sum kernel over a wrapping range, then reports on the done channel
module kernel_lane
    import asp_pkg::*;
#(
    parameter int LANE_ADDR_W = 6,
    parameter int DATA_W      = 32
) (
    input  logic                   pClk,
    input  logic                   rst_n,
    input  logic                   lane_req,
    input  kernel_op_t             lane_op,
    input  logic [LANE_ADDR_W-1:0] lane_base,
    input  logic [LANE_ADDR_W:0]   lane_len,
    input  logic [DATA_W-1:0]      lane_operand,
    input  logic                   done_ack,
    output logic                   lane_ack,
    output logic                   lane_busy,
    output logic                   done_req,
    output kernel_op_t             done_op,
    output logic [DATA_W-1:0]      done_result
);
    localparam int BANK_WORDS = 1 << LANE_ADDR_W;

    typedef enum logic [1:0] {IDLE, RUN, DONE, DONE_RELEASE} lane_state_t;

    lane_state_t            state;
    logic [DATA_W-1:0]      bank [BANK_WORDS];
    logic [LANE_ADDR_W-1:0] addr;
    logic [LANE_ADDR_W:0]   remain;
    logic [DATA_W-1:0]      operand;
    logic [DATA_W-1:0]      acc;
    kernel_op_t             op;
    logic                   launch;
    logic [DATA_W-1:0]      rd_word;
    logic                   mem_we;
    logic [DATA_W-1:0]      mem_wdata;

    // Accept a command only from idle, once per request
    assign launch = (state == IDLE) && lane_req && !lane_ack;

    assign lane_busy   = (state != IDLE);
    assign done_op     = op;
    assign done_result = acc;

    // Bank read is combinational, write lands at the clock edge
    assign rd_word   = bank[addr];
    assign mem_we    = (state == RUN) && (op != OP_SUM);
    assign mem_wdata = (op == OP_ADD) ? rd_word + operand : operand;

    always_ff @(posedge pClk) begin
        if (mem_we) begin
            bank[addr] <= mem_wdata;
        end
    end

    // Range walk and accumulation
    always_ff @(posedge pClk) begin
        if (launch) begin
            addr    <= lane_base;
            operand <= lane_operand;
            op      <= lane_op;
            acc     <= '0;
        end else if (state == RUN) begin
            // Address wraps at the bank size on its own
            addr <= addr + 1'b1;
            if (op == OP_SUM) begin
                acc <= acc + rd_word;
            end else begin
                acc <= acc + 1'b1;
            end
        end
    end

    always_ff @(posedge pClk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            lane_ack <= 1'b0;
            done_req <= 1'b0;
            remain   <= '0;
        end else begin
            // Launch handshake runs beside the kernel FSM
            if (launch) begin
                lane_ack <= 1'b1;
            end else if (!lane_req) begin
                lane_ack <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (launch) begin
                        remain <= lane_len;
                        if (lane_len == '0) begin
                            done_req <= 1'b1;
                            state    <= DONE;
                        end else begin
                            state <= RUN;
                        end
                    end
                end
                RUN: begin
                    remain <= remain - 1'b1;
                    if (remain == (LANE_ADDR_W + 1)'(1)) begin
                        done_req <= 1'b1;
                        state    <= DONE;
                    end
                end
                DONE: begin
                    // Parked here while the result FIFO is full
                    if (done_ack) begin
                        done_req <= 1'b0;
                        state    <= DONE_RELEASE;
                    end
                end
                DONE_RELEASE: begin
                    if (!done_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: source/mmio_csr.sv
// Host MMIO slave of the shell: stages kernel arguments, launches commands to a lane
// with a four-phase handshake and serves the status and result queue reads
module mmio_csr
    import asp_pkg::*;
#(
    parameter int  NUM_LANES    = 4,
    parameter int  LANE_ADDR_W  = 6,
    parameter int  DATA_W       = 32,
    parameter int  RESULT_DEPTH = 4,
    localparam int LANE_IDX_W   = width_for(NUM_LANES),
    localparam int CNT_W        = width_for(RESULT_DEPTH + 1)
) (
    input  logic                   pClk,
    input  logic                   rst_n,
    input  logic                   mmio_req,
    input  logic                   mmio_write,
    input  logic [2:0]             mmio_addr,
    input  logic [DATA_W-1:0]      mmio_wdata,
    output logic                   mmio_ack,
    output logic [DATA_W-1:0]      mmio_rdata,
    output logic [NUM_LANES-1:0]   lane_req,
    output kernel_op_t             lane_op,
    output logic [LANE_ADDR_W-1:0] lane_base,
    output logic [LANE_ADDR_W:0]   lane_len,
    output logic [DATA_W-1:0]      lane_operand,
    input  logic [NUM_LANES-1:0]   lane_ack,
    input  logic [NUM_LANES-1:0]   lane_busy,
    input  logic                   head_valid,
    input  logic [LANE_IDX_W-1:0]  head_lane,
    input  kernel_op_t             head_op,
    input  logic [DATA_W-1:0]      head_result,
    input  logic [CNT_W-1:0]       count,
    output logic                   pop
);
    localparam int BANK_WORDS = 1 << LANE_ADDR_W;

    typedef enum logic [1:0] {IDLE, LAUNCH, RELEASE, RESPOND} csr_state_t;

    csr_state_t             state;
    logic                   req_q;
    csr_addr_t              addr;
    logic                   wr_en;
    logic                   rd_en;
    logic [LANE_IDX_W-1:0]  wr_lane;
    logic [LANE_IDX_W-1:0]  cmd_lane;
    kernel_op_t             cmd_op;
    logic [LANE_ADDR_W-1:0] arg_base;
    logic [LANE_ADDR_W:0]   arg_len;
    logic [LANE_ADDR_W:0]   len_clamped;
    logic [DATA_W-1:0]      arg_operand;
    logic [DATA_W-1:0]      read_word;

    assign addr    = csr_addr_t'(mmio_addr);
    assign wr_lane = mmio_wdata[CMD_LANE_LSB +: LANE_IDX_W];
    assign wr_en   = (state == IDLE) && req_q && mmio_write;
    assign rd_en   = (state == IDLE) && req_q && !mmio_write;

    // Lengths beyond one bank collapse to a full bank pass
    assign len_clamped = (mmio_wdata > DATA_W'(BANK_WORDS)) ? (LANE_ADDR_W + 1)'(BANK_WORDS)
                                                            : mmio_wdata[LANE_ADDR_W:0];

    // Shared launch buses, held steady while the host is stalled on COMMAND
    assign lane_op      = cmd_op;
    assign lane_base    = arg_base;
    assign lane_len     = arg_len;
    assign lane_operand = arg_operand;

    always_comb begin
        read_word = '0;
        case (addr)
            CSR_ARG_BASE:    read_word = DATA_W'(arg_base);
            CSR_ARG_LEN:     read_word = DATA_W'(arg_len);
            CSR_ARG_OPERAND: read_word = arg_operand;
            CSR_STATUS: begin
                read_word[NUM_LANES-1:0]             = lane_busy;
                read_word[STATUS_COUNT_LSB +: CNT_W] = count;
            end
            CSR_RESULT_INFO: begin
                read_word[INFO_VALID_BIT]              = head_valid;
                read_word[INFO_LANE_LSB +: LANE_IDX_W] = head_lane;
                read_word[1:0]                         = head_op;
            end
            CSR_RESULT_DATA: read_word = head_result;
            default:         read_word = '0;
        endcase
    end

    // Argument staging and read data
    always_ff @(posedge pClk) begin
        if (wr_en) begin
            case (addr)
                CSR_ARG_BASE:    arg_base    <= mmio_wdata[LANE_ADDR_W-1:0];
                CSR_ARG_LEN:     arg_len     <= len_clamped;
                CSR_ARG_OPERAND: arg_operand <= mmio_wdata;
                CSR_COMMAND:     cmd_op      <= kernel_op_t'(mmio_wdata[1:0]);
                default: ;
            endcase
        end
        if (rd_en) begin
            mmio_rdata <= read_word;
        end
    end

    always_ff @(posedge pClk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            req_q    <= 1'b0;
            mmio_ack <= 1'b0;
            lane_req <= '0;
            cmd_lane <= '0;
            pop      <= 1'b0;
        end else begin
            req_q <= mmio_req;
            pop   <= 1'b0;
            case (state)
                IDLE: begin
                    if (wr_en && addr == CSR_COMMAND && int'(wr_lane) < NUM_LANES) begin
                        cmd_lane          <= wr_lane;
                        lane_req[wr_lane] <= 1'b1;
                        state             <= LAUNCH;
                    end else if (req_q) begin
                        // One pop per RESULT_DATA access, only with a valid head
                        pop      <= rd_en && (addr == CSR_RESULT_DATA) && head_valid;
                        mmio_ack <= 1'b1;
                        state    <= RESPOND;
                    end
                end
                LAUNCH: begin
                    if (lane_ack[cmd_lane]) begin
                        lane_req <= '0;
                        state    <= RELEASE;
                    end
                end
                RELEASE: begin
                    // Host waits here until the lane handshake is closed
                    if (!lane_ack[cmd_lane]) begin
                        mmio_ack <= 1'b1;
                        state    <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (!mmio_req) begin
                        mmio_ack <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: verification/asp_shell_tb.sv
// Self-checking testbench for the accelerator shell top level
// Drives four-phase MMIO traffic from a seeded xorshift stream and checks every
// result against a per-lane memory model
module asp_shell_tb
    import asp_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LANES      = 4;
    localparam int LANE_ADDR_W    = 6;
    localparam int DATA_W         = 32;
    localparam int RESULT_DEPTH   = 4;
    localparam int BANK_WORDS     = 1 << LANE_ADDR_W;
    localparam int LANE_IDX_W     = $clog2(NUM_LANES);
    localparam int TIMEOUT_CYCLES = 200 * 80 + 5000;

    logic              pClk       = 1'b0;
    logic              rst_n      = 1'b0;
    logic              mmio_req   = 1'b0;
    logic              mmio_write = 1'b0;
    logic [2:0]        mmio_addr  = '0;
    logic [DATA_W-1:0] mmio_wdata = '0;
    logic              mmio_ack;
    logic [DATA_W-1:0] mmio_rdata;

    logic [31:0] rng_state   = 32'h59d0_6a41;
    int          cycle_count = 0;
    int          pending_total = 0;

    // Reference model, bank contents and expected {op, result} per lane
    logic [31:0] model_mem [NUM_LANES][BANK_WORDS];
    logic [33:0] exp_q [NUM_LANES][$];

    asp_shell_top #(
        .NUM_LANES    (NUM_LANES),
        .LANE_ADDR_W  (LANE_ADDR_W),
        .DATA_W       (DATA_W),
        .RESULT_DEPTH (RESULT_DEPTH)
    ) i_dut (
        .pClk, .rst_n,
        .mmio_req, .mmio_write, .mmio_addr, .mmio_wdata, .mmio_ack, .mmio_rdata
    );

    always #20 pClk = ~pClk;

    always @(posedge pClk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // One four-phase host access, read data taken while ack is high
    task automatic bus_access(input logic wr, input csr_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge pClk);
        mmio_req   <= 1'b1;
        mmio_write <= wr;
        mmio_addr  <= addr;
        mmio_wdata <= wdata;
        do @(posedge pClk); while (mmio_ack !== 1'b1);
        rdata = mmio_rdata;
        mmio_req <= 1'b0;
        do @(posedge pClk); while (mmio_ack !== 1'b0);
    endtask

    task automatic csr_write(input csr_addr_t addr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(1'b1, addr, wdata, unused);
    endtask

    task automatic csr_read(input csr_addr_t addr, output logic [31:0] rdata);
        bus_access(1'b0, addr, '0, rdata);
    endtask

    task automatic read_status(output logic [31:0] status);
        csr_read(CSR_STATUS, status);
        check(32'(status[STATUS_COUNT_LSB +: 16] <= RESULT_DEPTH), 32'd1,
              "result count within FIFO depth");
    endtask

    task automatic wait_lanes_idle();
        logic [31:0] status;
        do read_status(status); while (status[NUM_LANES-1:0] != '0);
    endtask

    // Applies a command to the model in issue order and queues its result
    task automatic model_run(input int lane, input kernel_op_t op, input logic [31:0] base,
                             input logic [31:0] len, input logic [31:0] operand);
        int          n;
        int          a;
        logic [31:0] acc;
        n   = (len > BANK_WORDS) ? BANK_WORDS : int'(len);
        acc = '0;
        for (int i = 0; i < n; i++) begin
            a = (int'(base[LANE_ADDR_W-1:0]) + i) % BANK_WORDS;
            case (op)
                OP_FILL: model_mem[lane][a] = operand;
                OP_ADD:  model_mem[lane][a] = model_mem[lane][a] + operand;
                default: acc = acc + model_mem[lane][a];
            endcase
        end
        if (op != OP_SUM) begin
            acc = 32'(n);
        end
        exp_q[lane].push_back({op, acc});
        pending_total++;
    endtask

    task automatic launch(input int lane, input kernel_op_t op, input logic [31:0] base,
                          input logic [31:0] len, input logic [31:0] operand);
        csr_write(CSR_ARG_BASE, base);
        csr_write(CSR_ARG_LEN, len);
        csr_write(CSR_ARG_OPERAND, operand);
        csr_write(CSR_COMMAND, (32'(lane) << CMD_LANE_LSB) | 32'(op));
        model_run(lane, op, base, len, operand);
    endtask

    // Reads the head of the queue and matches it against that lane's oldest result
    task automatic read_result();
        logic [31:0] info;
        logic [31:0] data;
        logic [33:0] exp;
        int          lane;
        info = '0;
        while (info[INFO_VALID_BIT] !== 1'b1) begin
            csr_read(CSR_RESULT_INFO, info);
        end
        lane = int'(info[INFO_LANE_LSB +: LANE_IDX_W]);
        check(32'(exp_q[lane].size() != 0), 32'd1, "result from a lane with work outstanding");
        exp = exp_q[lane].pop_front();
        check(32'(info[1:0]), 32'(exp[33:32]), "opcode in RESULT_INFO");
        csr_read(CSR_RESULT_DATA, data);
        check(data, exp[31:0], $sformatf("result data of lane %0d", lane));
        pending_total--;
    endtask

    // Keeps the FIFO from filling while a lane with parked work is targeted
    task automatic safe_launch(input int lane, input kernel_op_t op, input logic [31:0] base,
                               input logic [31:0] len, input logic [31:0] operand);
        while (exp_q[lane].size() != 0 && pending_total >= RESULT_DEPTH) begin
            read_result();
        end
        launch(lane, op, base, len, operand);
    endtask

    task automatic drain_all();
        logic [31:0] status;
        while (pending_total > 0) begin
            read_result();
        end
        read_status(status);
        check(32'(status[STATUS_COUNT_LSB +: 16]), 32'd0, "result count after drain");
    endtask

    initial begin
        logic [31:0] status;
        logic [31:0] info;
        int          lane;
        kernel_op_t  op;
        logic [31:0] base;
        logic [31:0] len;
        logic [31:0] operand;

        repeat (10) @(posedge pClk);
        rst_n <= 1'b1;

        // Idle state after reset
        read_status(status);
        check(status, 32'd0, "STATUS after reset");
        csr_read(CSR_RESULT_INFO, info);
        check(32'(info[INFO_VALID_BIT]), 32'd0, "RESULT_INFO valid after reset");

        // Whole-bank fills, then sums over random and edge ranges
        for (int l = 0; l < NUM_LANES; l++) begin
            operand = next_rand();
            safe_launch(l, OP_FILL, 32'd0, 32'(BANK_WORDS), operand);
        end
        for (int k = 0; k < 16; k++) begin
            lane = int'(next_rand() % NUM_LANES);
            base = next_rand();
            len  = next_rand() % (BANK_WORDS + 1);
            safe_launch(lane, OP_SUM, base, len, 32'd0);
        end
        safe_launch(0, OP_SUM, 32'(BANK_WORDS - 3), 32'd10, 32'd0);
        safe_launch(1, OP_SUM, 32'd5, 32'd0, 32'd0);
        drain_all();

        // Random mix with reads interleaved
        for (int k = 0; k < 120; k++) begin
            lane    = int'(next_rand() % NUM_LANES);
            op      = kernel_op_t'(next_rand() % 3);
            base    = next_rand();
            len     = next_rand() % (BANK_WORDS + 8);
            operand = next_rand();
            safe_launch(lane, op, base, len, operand);
            if (next_rand() % 4 == 0 && pending_total > 0) begin
                read_result();
            end
        end
        drain_all();

        // Fill the FIFO, then park one more result in every lane
        for (int l = 0; l < NUM_LANES; l++) begin
            base    = next_rand();
            len     = next_rand() % BANK_WORDS;
            operand = next_rand();
            launch(l, OP_ADD, base, len, operand);
        end
        wait_lanes_idle();
        read_status(status);
        check(32'(status[STATUS_COUNT_LSB +: 16]), 32'(NUM_LANES), "count with full queue");
        for (int l = 0; l < NUM_LANES; l++) begin
            base = next_rand();
            len  = next_rand() % (BANK_WORDS + 1);
            launch(l, OP_SUM, base, len, 32'd0);
            read_status(status);
        end
        drain_all();

        // Second command to a lane that is still running
        launch(2, OP_SUM, 32'd0, 32'(BANK_WORDS), 32'd0);
        read_status(status);
        check(32'(status[2]), 32'd1, "lane 2 busy after launch");
        operand = next_rand();
        launch(2, OP_ADD, 32'd7, 32'd40, operand);
        drain_all();

        // Oversized length runs a single bank pass
        base    = next_rand();
        operand = next_rand();
        safe_launch(3, OP_FILL, base, 32'h0000_1234, operand);
        safe_launch(3, OP_SUM, 32'd0, 32'(BANK_WORDS), 32'd0);
        drain_all();

        $display("TEST OK");
        $finish;
    end

endmodule
